/* op_only_slice.f */
verilog/len5_isa_pkg.sv
verilog/expipe_pkg.sv
verilog/cdb_if.sv
verilog/modn_counter.sv
verilog/op_only_rs.sv
verilog/cdb_arbiter.sv
verilog/op_only_slice.sv
verif/tb_clock_gen.sv
verif/tb_op_only_slice.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the op_only_slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    --top-module tb_op_only_slice \
    -Mdir "$OBJ" \
    -f op_only_slice.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_op_only_slice" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
fi
exit 1

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int unsigned PERIOD = 100
) (
    output logic clk_o
);

    // Free-running clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

/* verif/tb_op_only_slice.sv */
`timescale 1ns/1ns

module tb_op_only_slice;
    import len5_isa_pkg::*;
    import expipe_pkg::*;

    logic clk_i, rst_n_i, flush_i;
    logic issue_valid_i, issue_ready_o, issue_rs1_ready_i;
    rob_idx_t issue_rs1_idx_i, issue_dest_idx_i;
    logic [XLEN-1:0] issue_rs1_value_i;
    logic eu_valid_i, eu_ready_o, eu_except_i;
    rob_idx_t eu_rob_idx_i;
    logic [XLEN-1:0] eu_value_i;
    except_code_t eu_except_code_i;
    logic cdb_valid_o, cdb_ready_i, cdb_except_o;
    rob_idx_t cdb_rob_idx_o;
    logic [XLEN-1:0] cdb_value_o;
    except_code_t cdb_except_code_o;

    // Station model with one slot per issued instruction
    rob_idx_t mdl_dest [0:255];
    rob_idx_t mdl_src [0:255];
    logic [XLEN-1:0] mdl_val [0:255];
    logic mdl_rdy [0:255];
    logic [7:0] mdl_head, mdl_tail;
    logic last_eu_q;
    int unsigned eu_acc_cnt;
    logic rs_xfer, eu_xfer, bc_ok;
    rob_idx_t bc_idx;
    logic [XLEN-1:0] bc_val;
    // Check enables driven by the stimulus
    logic idle_chk, full_chk, alt_chk;
    logic [31:0] lcg_state = 32'h260afc3b;

    tb_clock_gen #(.PERIOD(100)) u_clock_gen (.clk_o(clk_i));

    op_only_slice #(.RS_DEPTH(4)) u_op_only_slice (.*);

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    assign eu_xfer = eu_valid_i && eu_ready_o;
    assign rs_xfer = cdb_valid_o && cdb_ready_i && !eu_ready_o;
    // Broadcast comes from the source of the transfer
    assign bc_ok   = (eu_xfer && !eu_except_i) || rs_xfer;
    assign bc_idx  = eu_xfer ? eu_rob_idx_i : mdl_dest[mdl_head];
    assign bc_val  = eu_xfer ? eu_value_i : mdl_val[mdl_head];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mdl_head   <= '0;
            mdl_tail   <= '0;
            last_eu_q  <= 1'b1;
            eu_acc_cnt <= 0;
        end else begin
            if (eu_xfer) eu_acc_cnt <= eu_acc_cnt + 1;
            if (cdb_valid_o && cdb_ready_i) last_eu_q <= eu_xfer;
            if (flush_i) begin
                mdl_head <= mdl_tail;
            end else begin
                if (rs_xfer) mdl_head <= mdl_head + 8'd1;
                // Waiting slots pick up a matching clean broadcast
                for (int i = 0; i < 256; i++) begin
                    if (bc_ok && !mdl_rdy[i] && (mdl_src[i] == bc_idx)) begin
                        mdl_rdy[i] <= 1'b1;
                        mdl_val[i] <= bc_val;
                    end
                end
                // New slot may take the broadcast of the same edge
                if (issue_valid_i && issue_ready_o) begin
                    mdl_tail           <= mdl_tail + 8'd1;
                    mdl_dest[mdl_tail] <= issue_dest_idx_i;
                    mdl_src[mdl_tail]  <= issue_rs1_idx_i;
                    mdl_rdy[mdl_tail]  <= issue_rs1_ready_i
                                          || (bc_ok && (bc_idx == issue_rs1_idx_i));
                    mdl_val[mdl_tail]  <= issue_rs1_ready_i ? issue_rs1_value_i
                                          : (bc_ok && (bc_idx == issue_rs1_idx_i)) ? bc_val
                                          : issue_rs1_value_i;
                end
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_rs_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rs_xfer |-> (mdl_head != mdl_tail) && mdl_rdy[mdl_head] && !cdb_except_o
        && (cdb_rob_idx_o == mdl_dest[mdl_head]) && (cdb_value_o == mdl_val[mdl_head]))
        else report_value_error("station result differs from the model");

    a_eu_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        eu_xfer |-> cdb_valid_o && (cdb_rob_idx_o == eu_rob_idx_i)
        && (cdb_value_o == eu_value_i) && (cdb_except_o == eu_except_i)
        && (cdb_except_code_o == eu_except_code_i))
        else report_value_error("execution unit result not passed through");

    a_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        idle_chk |-> !cdb_valid_o && !eu_ready_o && issue_ready_o)
        else report_value_error("outputs not idle after reset or flush");

    a_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        full_chk |-> !issue_ready_o)
        else report_value_error("issue_ready_o high with a full station");

    // Stalled CDB holds its request
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cdb_valid_o && !cdb_ready_i && !flush_i && !eu_valid_i)
        |=> cdb_valid_o && $stable(cdb_rob_idx_o) && $stable(cdb_value_o)
        && $stable(cdb_except_o))
        else report_value_error("CDB request changed before acceptance");

    // Tie goes to the source not served last
    a_alt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (alt_chk && eu_valid_i && cdb_ready_i && (mdl_head != mdl_tail))
        |-> cdb_valid_o && (eu_ready_o == !last_eu_q))
        else report_value_error("round-robin grant out of turn");

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic report_value_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Something failed");
        $fatal(1, "stopping on timeout");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rob_idx_t rand_idx();
        logic [31:0] r;
        r = lcg_next();
        return r[19:16];
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    task automatic wait_issue_ready();
        int n;
        n = 0;
        while (!issue_ready_o && (n < 50)) begin
            @(negedge clk_i);
            n++;
        end
        if (!issue_ready_o) report_timeout("the station to accept an issue");
    endtask

    // One issue accepted at the next rising edge
    task automatic issue_op(input logic rdy, input rob_idx_t src,
                            input logic [XLEN-1:0] val, input rob_idx_t dest);
        wait_issue_ready();
        issue_valid_i     = 1'b1;
        issue_rs1_ready_i = rdy;
        issue_rs1_idx_i   = src;
        issue_rs1_value_i = val;
        issue_dest_idx_i  = dest;
        @(negedge clk_i);
        issue_valid_i     = 1'b0;
    endtask

    task automatic issue_random_ready();
        issue_op(1'b1, rand_idx(), rand_word(), rand_idx());
    endtask

    // EU request held until the CDB takes it
    task automatic eu_send(input rob_idx_t idx, input logic [XLEN-1:0] val,
                           input logic exc, input except_code_t code);
        int unsigned cnt0;
        int n;
        cnt0             = eu_acc_cnt;
        eu_valid_i       = 1'b1;
        eu_rob_idx_i     = idx;
        eu_value_i       = val;
        eu_except_i      = exc;
        eu_except_code_i = code;
        @(negedge clk_i);
        n = 1;
        while ((eu_acc_cnt == cnt0) && (n < 50)) begin
            @(negedge clk_i);
            n++;
        end
        eu_valid_i = 1'b0;
        if (eu_acc_cnt == cnt0) report_timeout("the CDB to accept an EU result");
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((mdl_head != mdl_tail) && (n < 100)) begin
            @(negedge clk_i);
            n++;
        end
        if (mdl_head != mdl_tail) report_timeout("the station to release its results");
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        rob_idx_t src;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_rs1_ready_i = 1'b0;
        issue_rs1_idx_i = '0;
        issue_rs1_value_i = '0;
        issue_dest_idx_i = '0;
        eu_valid_i = 1'b0;
        eu_rob_idx_i = '0;
        eu_value_i = '0;
        eu_except_i = 1'b0;
        eu_except_code_i = E_UNKNOWN;
        cdb_ready_i = 1'b0;
        idle_chk = 1'b0;
        full_chk = 1'b0;
        alt_chk = 1'b0;
        repeat (10) @(negedge clk_i);
        rst_n_i  = 1'b1;
        idle_chk = 1'b1;
        @(negedge clk_i);
        idle_chk = 1'b0;

        // Station fills up behind a stalled ROB
        repeat (4) issue_random_ready();
        full_chk = 1'b1;
        repeat (4) @(negedge clk_i);
        full_chk = 1'b0;

        // Station and EU compete and the station takes the first tie
        alt_chk     = 1'b1;
        cdb_ready_i = 1'b1;
        repeat (5) eu_send(rand_idx(), rand_word(), 1'b0, E_UNKNOWN);
        wait_drained();
        alt_chk = 1'b0;

        // Ready operands leave in issue order
        repeat (6) issue_random_ready();
        wait_drained();

        // Operand from a later EU broadcast
        src = rand_idx();
        issue_op(1'b0, src, rand_word(), rand_idx());
        repeat (2) @(negedge clk_i);
        eu_send(src, rand_word(), 1'b0, E_UNKNOWN);
        wait_drained();

        // Issue and broadcast on the same edge
        wait_issue_ready();
        src = rand_idx();
        issue_valid_i     = 1'b1;
        issue_rs1_ready_i = 1'b0;
        issue_rs1_idx_i   = src;
        issue_dest_idx_i  = rand_idx();
        eu_valid_i        = 1'b1;
        eu_rob_idx_i      = src;
        eu_value_i        = rand_word();
        eu_except_i       = 1'b0;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
        eu_valid_i    = 1'b0;
        wait_drained();

        // Excepting match must not wake
        src = rand_idx();
        issue_op(1'b0, src, rand_word(), rand_idx());
        eu_send(src, rand_word(), 1'b1, E_ILLEGAL_INSTR);
        repeat (3) @(negedge clk_i);
        eu_send(src, rand_word(), 1'b0, E_UNKNOWN);
        wait_drained();

        // Flush of a full station
        cdb_ready_i = 1'b0;
        repeat (4) issue_random_ready();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i  = 1'b0;
        idle_chk = 1'b1;
        @(negedge clk_i);
        idle_chk    = 1'b0;
        cdb_ready_i = 1'b1;
        repeat (8) @(negedge clk_i);

        $display("Everything OK");
        $finish;
    end

endmodule

/* verilog/cdb_arbiter.sv */
`timescale 1ns/1ns

module cdb_arbiter (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Reservation station source
    cdb_if.arbiter                        rs_cdb,
    // External execution unit source
    input  logic                          eu_valid_i,
    output logic                          eu_ready_o,
    input  expipe_pkg::rob_idx_t          eu_rob_idx_i,
    input  logic [len5_isa_pkg::XLEN-1:0] eu_value_i,
    input  logic                          eu_except_i,
    input  len5_isa_pkg::except_code_t    eu_except_code_i,
    // Towards the ROB
    output logic                          cdb_valid_o,
    input  logic                          cdb_ready_i,
    output expipe_pkg::cdb_data_t         cdb_data_o,
    // Broadcast of accepted transfers
    cdb_if.producer                       bcast
);
    import expipe_pkg::*;

    // Source granted by the last completed transfer
    typedef enum logic {
        GNT_RS,
        GNT_EU
    } gnt_t;

    gnt_t      last_q;
    logic      gnt_rs;
    logic      gnt_eu;
    logic      xfer;
    cdb_data_t eu_data;

    // EU ports packed as a CDB payload
    assign eu_data.rob_idx       = eu_rob_idx_i;
    assign eu_data.res_value     = eu_value_i;
    assign eu_data.except_raised = eu_except_i;
    assign eu_data.except_code   = eu_except_code_i;

    // ----------------------------------------
    // Round-robin grant
    // ----------------------------------------
    // On a tie the source not served last wins
    assign gnt_rs = rs_cdb.valid && (!eu_valid_i || (last_q == GNT_EU));
    assign gnt_eu = eu_valid_i && !gnt_rs;

    assign cdb_valid_o  = gnt_rs || gnt_eu;
    assign cdb_data_o   = gnt_rs ? rs_cdb.data : eu_data;
    assign xfer         = cdb_valid_o && cdb_ready_i;

    // ROB ready forwarded to the winner only
    assign rs_cdb.ready = gnt_rs && cdb_ready_i;
    assign eu_ready_o   = gnt_eu && cdb_ready_i;

    // Reset to EU so the station takes the first tie
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q <= GNT_EU;
        end else if (xfer) begin
            last_q <= gnt_rs ? GNT_RS : GNT_EU;
        end
    end

    // Snooped by the stations in the transfer cycle
    assign bcast.valid = xfer;
    assign bcast.data  = cdb_data_o;

    // Only one source ever completes per cycle
    a_one_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rs_cdb.ready && eu_ready_o));

endmodule

/* verilog/cdb_if.sv */
`timescale 1ns/1ns

interface cdb_if;
    import expipe_pkg::*;

    // Handshake
    logic      valid;
    logic      ready;

    // Payload, stable while valid and not ready
    cdb_data_t data;

    // Source of a transfer
    modport producer (
        output valid, data,
        input  ready
    );

    // Sink side, owns ready
    modport arbiter (
        input  valid, data,
        output ready
    );

    // Passive listeners of the broadcast
    modport snoop (input valid, data);

endinterface

/* verilog/expipe_pkg.sv */
package expipe_pkg;

    // ----------------------------------------
    // Reorder buffer
    // ----------------------------------------
    // Index width into the ROB
    localparam int unsigned ROB_IDX_LEN = 4;

    // One ROB entry index
    typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

    // ----------------------------------------
    // Common data bus
    // ----------------------------------------
    // Payload broadcast to the ROB and snooped by the stations
    typedef struct packed {
        // Destination ROB entry
        rob_idx_t                             rob_idx;
        // Result written back
        logic [len5_isa_pkg::XLEN-1:0]        res_value;
        // Set when the producer trapped
        logic                                 except_raised;
        // Meaningful only with except_raised
        len5_isa_pkg::except_code_t           except_code;
    } cdb_data_t;

endpackage

/* verilog/len5_isa_pkg.sv */
package len5_isa_pkg;

    // Integer register width
    localparam int unsigned XLEN = 64;

    // ----------------------------------------
    // Exception codes
    // ----------------------------------------
    // Values follow the RISC-V mcause encoding
    // Reserved value 10 is used as the "no exception" code
    typedef enum logic [3:0] {
        E_I_ADDR_MISALIGNED  = 4'd0,
        E_I_ACCESS_FAULT     = 4'd1,
        E_ILLEGAL_INSTR      = 4'd2,
        E_BREAKPOINT         = 4'd3,
        E_LD_ADDR_MISALIGNED = 4'd4,
        E_LD_ACCESS_FAULT    = 4'd5,
        E_ST_ADDR_MISALIGNED = 4'd6,
        E_ST_ACCESS_FAULT    = 4'd7,
        E_ENV_CALL_UMODE     = 4'd8,
        E_ENV_CALL_SMODE     = 4'd9,
        E_UNKNOWN            = 4'd10,
        E_ENV_CALL_MMODE     = 4'd11,
        E_INSTR_PAGE_FAULT   = 4'd12,
        E_LD_PAGE_FAULT      = 4'd13,
        E_ST_PAGE_FAULT      = 4'd15
    } except_code_t;

endpackage

/* verilog/modn_counter.sv */
`timescale 1ns/1ns

module modn_counter #(
    parameter int unsigned N = 4
) (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 en_i,
    input  logic                                 clr_i,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] count_o,
    output logic                                 tc_o
);

    localparam int unsigned W = (N > 1) ? $clog2(N) : 1;

    // Clear wins over enable
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_o <= '0;
        end else if (clr_i) begin
            count_o <= '0;
        end else if (en_i) begin
            // Wrap at N-1
            count_o <= tc_o ? '0 : count_o + 1'b1;
        end
    end

    // Last value before wrapping
    assign tc_o = (count_o == W'(N - 1));

    // Count never leaves the modulo range
    a_count_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_o < N);

endmodule

/* verilog/op_only_rs.sv */
`timescale 1ns/1ns

module op_only_rs #(
    parameter int unsigned RS_DEPTH = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    // Issue handshake
    input  logic                            issue_valid_i,
    output logic                            issue_ready_o,
    // Issued instruction
    input  logic                            rs1_ready_i,
    input  expipe_pkg::rob_idx_t            rs1_idx_i,
    input  logic [len5_isa_pkg::XLEN-1:0]   rs1_value_i,
    input  expipe_pkg::rob_idx_t            dest_idx_i,
    // Result towards the CDB arbiter
    cdb_if.producer                         rs_cdb,
    // Broadcast from the CDB
    cdb_if.snoop                            bcast
);
    import len5_isa_pkg::*;
    import expipe_pkg::*;

    localparam int unsigned RS_IDX_LEN = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    // Entry status, cleared on reset and flush
    logic [RS_DEPTH-1:0]   valid_q;
    logic [RS_DEPTH-1:0]   ready_q;
    // Entry payload
    rob_idx_t              src_idx_q [0:RS_DEPTH-1];
    logic [XLEN-1:0]       value_q   [0:RS_DEPTH-1];
    rob_idx_t              dest_q    [0:RS_DEPTH-1];

    // FIFO pointers
    logic [RS_IDX_LEN-1:0] head_idx;
    logic [RS_IDX_LEN-1:0] tail_idx;

    logic                  push;
    logic                  pop;
    logic [RS_DEPTH-1:0]   push_sel;
    logic [RS_DEPTH-1:0]   pop_sel;
    logic [RS_DEPTH-1:0]   wake;
    logic                  bcast_ok;
    logic                  issue_hit;
    logic                  in_ready;
    logic [XLEN-1:0]       in_value;

    // ----------------------------------------
    // Handshakes
    // ----------------------------------------
    // Room only while the tail slot is empty
    assign issue_ready_o = !valid_q[tail_idx];
    assign push          = issue_valid_i && issue_ready_o;

    // Head leaves once its operand is in
    assign rs_cdb.valid  = valid_q[head_idx] && ready_q[head_idx];
    assign pop           = rs_cdb.valid && rs_cdb.ready;

    // ----------------------------------------
    // CDB snooping
    // ----------------------------------------
    // Excepting results never carry a usable value
    assign bcast_ok  = bcast.valid && !bcast.data.except_raised;

    // Operand landing in the same cycle as its issue
    assign issue_hit = bcast_ok && (bcast.data.rob_idx == rs1_idx_i);
    assign in_ready  = rs1_ready_i || issue_hit;
    assign in_value  = rs1_ready_i ? rs1_value_i : bcast.data.res_value;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            push_sel[i] = push && (tail_idx == RS_IDX_LEN'(i));
            pop_sel[i]  = pop && (head_idx == RS_IDX_LEN'(i));
            // Only waiting entries listen
            wake[i]     = valid_q[i] && !ready_q[i] && bcast_ok
                          && (bcast.data.rob_idx == src_idx_q[i]);
        end
    end

    // Status bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            ready_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (push_sel[i]) begin
                    valid_q[i] <= 1'b1;
                    ready_q[i] <= in_ready;
                end else if (pop_sel[i]) begin
                    valid_q[i] <= 1'b0;
                    ready_q[i] <= 1'b0;
                end else if (wake[i]) begin
                    ready_q[i] <= 1'b1;
                end
            end
        end
    end

    // Payload, written on push or wake-up
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (push_sel[i]) begin
                src_idx_q[i] <= rs1_idx_i;
                value_q[i]   <= in_value;
                dest_q[i]    <= dest_idx_i;
            end else if (wake[i]) begin
                value_q[i]   <= bcast.data.res_value;
            end
        end
    end

    // ----------------------------------------
    // Pointers
    // ----------------------------------------
    modn_counter #(.N(RS_DEPTH)) head_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (pop),
        .clr_i   (flush_i),
        .count_o (head_idx),
        .tc_o    ()
    );

    modn_counter #(.N(RS_DEPTH)) tail_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (push),
        .clr_i   (flush_i),
        .count_o (tail_idx),
        .tc_o    ()
    );

    // Operand passes straight through, never traps
    assign rs_cdb.data.rob_idx       = dest_q[head_idx];
    assign rs_cdb.data.res_value     = value_q[head_idx];
    assign rs_cdb.data.except_raised = 1'b0;
    assign rs_cdb.data.except_code   = E_UNKNOWN;

    // Full station holds its tail pointer until a slot frees
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (issue_valid_i && valid_q[tail_idx] && !flush_i) |=> $stable(tail_idx));

    // Pending result sits on a valid head and does not change
    a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs_cdb.valid && !rs_cdb.ready && !flush_i)
        |=> rs_cdb.valid && valid_q[head_idx] && $stable(rs_cdb.data));

endmodule

/* verilog/op_only_slice.sv */
`timescale 1ns/1ns

module op_only_slice #(
    parameter int unsigned RS_DEPTH = 4
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    // Issue
    input  logic                          issue_valid_i,
    output logic                          issue_ready_o,
    input  logic                          issue_rs1_ready_i,
    input  expipe_pkg::rob_idx_t          issue_rs1_idx_i,
    input  logic [len5_isa_pkg::XLEN-1:0] issue_rs1_value_i,
    input  expipe_pkg::rob_idx_t          issue_dest_idx_i,
    // External execution unit
    input  logic                          eu_valid_i,
    output logic                          eu_ready_o,
    input  expipe_pkg::rob_idx_t          eu_rob_idx_i,
    input  logic [len5_isa_pkg::XLEN-1:0] eu_value_i,
    input  logic                          eu_except_i,
    input  len5_isa_pkg::except_code_t    eu_except_code_i,
    // CDB towards the ROB
    output logic                          cdb_valid_o,
    input  logic                          cdb_ready_i,
    output expipe_pkg::rob_idx_t          cdb_rob_idx_o,
    output logic [len5_isa_pkg::XLEN-1:0] cdb_value_o,
    output logic                          cdb_except_o,
    output len5_isa_pkg::except_code_t    cdb_except_code_o
);
    import expipe_pkg::*;

    cdb_data_t cdb_data;

    // Station result port and CDB broadcast
    cdb_if rs_cdb ();
    cdb_if bcast ();

    // Listeners cannot stall the broadcast
    assign bcast.ready = 1'b1;

    op_only_rs #(.RS_DEPTH(RS_DEPTH)) u_op_only_rs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .rs1_ready_i   (issue_rs1_ready_i),
        .rs1_idx_i     (issue_rs1_idx_i),
        .rs1_value_i   (issue_rs1_value_i),
        .dest_idx_i    (issue_dest_idx_i),
        .rs_cdb        (rs_cdb.producer),
        .bcast         (bcast.snoop)
    );

    cdb_arbiter u_cdb_arbiter (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .rs_cdb           (rs_cdb.arbiter),
        .eu_valid_i       (eu_valid_i),
        .eu_ready_o       (eu_ready_o),
        .eu_rob_idx_i     (eu_rob_idx_i),
        .eu_value_i       (eu_value_i),
        .eu_except_i      (eu_except_i),
        .eu_except_code_i (eu_except_code_i),
        .cdb_valid_o      (cdb_valid_o),
        .cdb_ready_i      (cdb_ready_i),
        .cdb_data_o       (cdb_data),
        .bcast            (bcast.producer)
    );

    // Payload fields out to the ROB
    assign cdb_rob_idx_o     = cdb_data.rob_idx;
    assign cdb_value_o       = cdb_data.res_value;
    assign cdb_except_o      = cdb_data.except_raised;
    assign cdb_except_code_o = cdb_data.except_code;

endmodule
